/* hdl/axi4s2v_consts.svh */
// Build constants of the stream to video converter
// FIFO depth is 2**AXI4S2V_FIFO_AW words
// The ready level must stay below the FIFO depth
`ifndef AXI4S2V_CONSTS_SVH
`define AXI4S2V_CONSTS_SVH

// Stream and pixel widths
`define AXI4S2V_AIDW            32
`define AXI4S2V_PXDW            8
`define AXI4S2V_PX_PER_WORD     4

// FIFO geometry and start threshold
`define AXI4S2V_FIFO_AW         5
`define AXI4S2V_FIFO_RDY_LVL    8

`define AXI4S2V_XWID            10
// Cycles from first pop to o_hstr, less the state register
`define AXI4S2V_POP2VO          2

`endif

/* hdl/axis_pkg.sv */
// Stream side and FIFO types
// Widths follow axi4s2v_consts.svh
`default_nettype none

`include "axi4s2v_consts.svh"

package axis_pkg;

   // One stream beat, four zero-padded pixels
   typedef logic [`AXI4S2V_AIDW-1:0]    axis_word_t;

   typedef logic [`AXI4S2V_FIFO_AW-1:0] fifo_addr_t;
   // One extra bit so a full FIFO is representable
   typedef logic [`AXI4S2V_FIFO_AW:0]   fifo_lvl_t;

endpackage

`default_nettype wire

/* hdl/video_pkg.sv */
// Video side types
// Line counts saturate at 2**AXI4S2V_XWID - 1
`default_nettype none

`include "axi4s2v_consts.svh"

package video_pkg;

   typedef logic [`AXI4S2V_PXDW-1:0]                pixel_t;
   typedef logic [`AXI4S2V_XWID-1:0]                line_cnt_t;
   typedef logic [$clog2(`AXI4S2V_PX_PER_WORD)-1:0] px_sel_t;

   // [4] i_fend outside back blank, [3] pop while empty,
   // [2] empty at i_hstr, [1] not ready at i_hstr, [0] FIFO ready
   typedef logic [4:0]                              vcnv_sts_t;

   // Output timing FSM
   typedef enum logic [3:0] {
      VOTM_IDLE,
      VOTM_FSTR,
      VOTM_FVBLK,
      VOTM_HSTR,
      VOTM_HACT,
      VOTM_HEND,
      VOTM_HBLK,
      VOTM_BVBLK,
      VOTM_FEND
   } votm_state_t;

endpackage

`default_nettype wire

/* hdl/fifo_rd_if.sv */
// FIFO read side shared by the unpacker and the timing monitor
// rdata is valid one cycle after pop
`default_nettype none

interface fifo_rd_if;
   import axis_pkg::*;

   logic       pop;
   axis_word_t rdata;
   logic       empty;
   fifo_lvl_t  level;

   // FIFO owner
   modport fifo_mp   (input pop, output rdata, output empty, output level);
   // Pixel unpacker pops and reads data
   modport unpack_mp (output pop, input rdata, input empty);
   // Timing FSM watches fill state only
   modport mon_mp    (input empty, input level);

endinterface

`default_nettype wire

/* hdl/stream_fifo.sv */
// Synchronous FIFO for stream words
// Push while full and pop while empty are dropped
// Read data register changes only on an accepted pop
`default_nettype none

`include "axi4s2v_consts.svh"

module stream_fifo (
   input  logic                 pclk,
   input  logic                 prst_n,
   input  logic                 i_push,
   input  axis_pkg::axis_word_t i_wdata,
   output logic                 o_full,
   fifo_rd_if.fifo_mp           rd
);
   import axis_pkg::*;

   axis_word_t mem [2**`AXI4S2V_FIFO_AW];
   fifo_addr_t wptr;
   fifo_addr_t rptr;
   fifo_lvl_t  lvl;
   logic       wr_en;
   logic       rd_en;

   // Level MSB is set only at full depth
   assign o_full   = lvl[`AXI4S2V_FIFO_AW];
   assign rd.empty = (lvl == '0);
   assign rd.level = lvl;

   assign wr_en = i_push & ~o_full;
   assign rd_en = rd.pop & ~rd.empty;

   // --------------------
   // Storage
   always_ff @(posedge pclk) begin
      if (wr_en) begin
         mem[wptr] <= i_wdata;
      end
      if (rd_en) begin
         rd.rdata <= mem[rptr];
      end
   end

   // --------------------
   // Pointers and level
   always_ff @(posedge pclk) begin
      if (!prst_n) begin
         wptr <= '0;
         rptr <= '0;
         lvl  <= '0;
      end else begin
         if (wr_en) begin
            wptr <= wptr + 1'b1;
         end
         if (rd_en) begin
            rptr <= rptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   lvl <= lvl + 1'b1;
            2'b01:   lvl <= lvl - 1'b1;
            default: lvl <= lvl;
         endcase
      end
   end

endmodule

`default_nettype wire

/* hdl/vin_tracker.sv */
// Tracks the blanking phase of the input frame
// Each flag follows its strobe by one cycle
`default_nettype none

module vin_tracker (
   input  logic pclk,
   input  logic prst_n,
   input  logic i_fstr,
   input  logic i_vstr,
   input  logic i_vend,
   input  logic i_fend,
   output logic o_fblk,
   output logic o_bblk,
   output logic o_sync
);

   // Front blank  i_fstr .. i_vstr
   // Back blank   i_vend .. i_fend
   // Sync         i_fend .. next i_fstr
   always_ff @(posedge pclk) begin
      if (!prst_n) begin
         o_fblk <= 1'b0;
         o_bblk <= 1'b0;
         o_sync <= 1'b0;
      end else begin
         o_fblk <= (o_fblk | i_fstr) & ~i_vstr;
         o_bblk <= (o_bblk | i_vend) & ~i_fend;
         o_sync <= (o_sync | i_fend) & ~i_fstr;
      end
   end

endmodule

`default_nettype wire

/* hdl/vout_timing.sv */
// Output timing FSM, pop window and status flags
// Assumes i_vstr comes with the first i_hstr and i_hend with the last i_href
// Horizontal blank must be at least 3 cycles
// If not ready at i_vstr, output starts at the next input line
`default_nettype none

`include "axi4s2v_consts.svh"

module vout_timing (
   input  logic                  pclk,
   input  logic                  prst_n,
   input  logic                  i_fstr,
   input  logic                  i_fend,
   input  logic                  i_vstr,
   input  logic                  i_vend,
   input  logic                  i_hstr,
   input  logic                  i_hend,
   input  logic                  i_fblk,
   input  logic                  i_bblk,
   input  logic                  i_sync,
   input  logic                  i_pop_cyc_str,
   fifo_rd_if.mon_mp             mon,
   output logic                  o_pop_vld,
   output logic                  o_pop_str,
   output logic                  o_fstr,
   output logic                  o_fend,
   output logic                  o_vstr,
   output logic                  o_vend,
   output logic                  o_hstr,
   output logic                  o_hend,
   output logic                  o_href,
   output video_pkg::vcnv_sts_t  o_vcnv_sts
);
   import axis_pkg::*;
   import video_pkg::*;

   votm_state_t                state;
   votm_state_t                state_nxt;
   logic [`AXI4S2V_POP2VO-1:0] pop_str_q;
   logic [`AXI4S2V_POP2VO-1:0] hend_q;
   logic                       pop2vo_sig;
   logic                       hacto_end;
   logic                       pop_vstr;
   logic                       pop_hstr;
   logic                       hend_pend;
   logic                       hend_line;
   logic                       pop_close;
   logic                       pop_cyc_q;
   line_cnt_t                  vo_line;
   logic                       fifo_rdy;
   logic                       sts_nordy;
   logic                       sts_empty;
   logic                       sts_udf;
   logic                       sts_noeof;

   // --------------------
   // Pop window
   assign pop_vstr  = (state == VOTM_FVBLK) & i_fblk & i_vstr & fifo_rdy;
   assign pop_hstr  = i_hstr & (((state == VOTM_FVBLK) & ~i_fblk) |
                                (state == VOTM_HEND) | (state == VOTM_HBLK));
   assign o_pop_str = pop_vstr | pop_hstr;

   // Close at the next word boundary once the line has ended
   assign hend_line = i_hend | hend_pend;
   assign pop_close = o_pop_vld & hend_line & i_pop_cyc_str;

   assign pop2vo_sig = pop_str_q[`AXI4S2V_POP2VO-1];
   assign hacto_end  = hend_q[`AXI4S2V_POP2VO-1];

   // --------------------
   // FSM
   always_comb begin
      state_nxt = state;
      case (state)
         VOTM_IDLE:  if (i_fstr) state_nxt = VOTM_FSTR;
         VOTM_FSTR:  state_nxt = VOTM_FVBLK;
         VOTM_FVBLK: begin
            if (pop2vo_sig) state_nxt = VOTM_HSTR;
            else if (i_fend) state_nxt = VOTM_FEND;
         end
         VOTM_HSTR:  state_nxt = VOTM_HACT;
         VOTM_HACT:  if (hacto_end) state_nxt = VOTM_HEND;
         VOTM_HEND: begin
            // Last line ends before or after i_fend
            if (i_bblk & ~i_fend) state_nxt = VOTM_BVBLK;
            else if (i_sync | i_fend) state_nxt = VOTM_FEND;
            else state_nxt = VOTM_HBLK;
         end
         VOTM_HBLK: begin
            if (pop2vo_sig) state_nxt = VOTM_HSTR;
            else if (i_fend) state_nxt = VOTM_FEND;
         end
         VOTM_BVBLK: if (i_fend) state_nxt = VOTM_FEND;
         VOTM_FEND:  state_nxt = i_fstr ? VOTM_FSTR : VOTM_IDLE;
         default:    state_nxt = VOTM_IDLE;
      endcase
   end

   assign o_fstr = (state == VOTM_FSTR);
   assign o_fend = (state == VOTM_FEND);
   assign o_hstr = (state == VOTM_HSTR);
   assign o_hend = (state == VOTM_HEND);
   assign o_href = (state == VOTM_HSTR) | (state == VOTM_HACT) | (state == VOTM_HEND);
   assign o_vend = o_hend & (i_bblk | i_sync);

   assign o_vcnv_sts = {sts_noeof, sts_udf, sts_empty, sts_nordy, fifo_rdy};

   always_ff @(posedge pclk) begin
      if (!prst_n) begin
         state     <= VOTM_IDLE;
         o_pop_vld <= 1'b0;
         hend_pend <= 1'b0;
         pop_str_q <= '0;
         hend_q    <= '0;
         pop_cyc_q <= 1'b0;
         vo_line   <= '0;
         o_vstr    <= 1'b0;
         fifo_rdy  <= 1'b0;
         sts_nordy <= 1'b0;
         sts_empty <= 1'b0;
         sts_udf   <= 1'b0;
         sts_noeof <= 1'b0;
      end else begin
         state     <= state_nxt;
         o_pop_vld <= (o_pop_str | o_pop_vld) & ~pop_close;
         hend_pend <= o_pop_vld & hend_line & ~i_pop_cyc_str;
         pop_str_q <= {pop_str_q[`AXI4S2V_POP2VO-2:0], o_pop_str};
         hend_q    <= {hend_q[`AXI4S2V_POP2VO-2:0], i_hend};
         pop_cyc_q <= i_pop_cyc_str;
         // Output line index within the frame
         if (o_fstr) begin
            vo_line <= '0;
         end else if (o_hstr && vo_line != '1) begin
            vo_line <= vo_line + 1'b1;
         end
         o_vstr    <= (state_nxt == VOTM_HSTR) & (vo_line == '0);
         // Sticky status
         fifo_rdy  <= (fifo_rdy |
                       (mon.level > fifo_lvl_t'(`AXI4S2V_FIFO_RDY_LVL))) & ~o_vend;
         sts_nordy <= (sts_nordy | (i_hstr & ~fifo_rdy)) & ~i_fend;
         sts_empty <= (sts_empty | (i_hstr & mon.empty)) & ~i_fend;
         sts_udf   <= (sts_udf | (o_pop_vld & pop_cyc_q & mon.empty)) & ~i_fend;
         sts_noeof <= (sts_noeof | (i_fend & ~i_bblk)) & ~i_vend;
      end
   end

endmodule

`default_nettype wire

/* hdl/pixel_unpack.sv */
// Pops stream words and slices them into pixels
// Zero-padded format with pixel 0 in the low byte
// Pixel leaves two cycles after the pop window opens
`default_nettype none

`include "axi4s2v_consts.svh"

module pixel_unpack (
   input  logic              pclk,
   input  logic              prst_n,
   input  logic              i_pop_vld,
   input  logic              i_pop_str,
   fifo_rd_if.unpack_mp      fifo,
   output logic              o_pop_cyc_str,
   output video_pkg::pixel_t o_pdat
);
   import video_pkg::*;

   px_sel_t px_cnt;
   px_sel_t px_cnt_nxt;
   px_sel_t px_sel_q;
   pixel_t  px_muxd;

   // Pixel position within the current word
   always_comb begin
      px_cnt_nxt = px_cnt;
      if (i_pop_str) begin
         px_cnt_nxt = '0;
      end else if (i_pop_vld) begin
         px_cnt_nxt = px_cnt + 1'b1;
      end
   end

   // Next cycle starts a new word
   assign o_pop_cyc_str = (px_cnt_nxt == '0);

   assign fifo.pop = i_pop_vld & (px_cnt == '0) & ~fifo.empty;

   // Select lines up with the word returned one cycle after the pop
   assign px_muxd = fifo.rdata[px_sel_q * `AXI4S2V_PXDW +: `AXI4S2V_PXDW];

   // --------------------
   always_ff @(posedge pclk) begin
      if (!prst_n) begin
         px_cnt   <= '0;
         px_sel_q <= '0;
      end else begin
         px_cnt   <= px_cnt_nxt;
         px_sel_q <= px_cnt;
      end
   end

   always_ff @(posedge pclk) begin
      o_pdat <= px_muxd;
   end

endmodule

`default_nettype wire

/* hdl/axi4s2v.sv */
// AXI4-Stream to video converter, single clock domain
// Active line width must be a multiple of four pixels
// tlast and i_href are accepted but unused, line ends come from i_hend
// tready drops only when the FIFO is full
`default_nettype none

module axi4s2v (
   input  logic                  pclk,
   input  logic                  prst_n,
   // AXI4-Stream
   input  axis_pkg::axis_word_t  tdata,
   input  logic                  tvalid,
   input  logic                  tlast,
   output logic                  tready,
   output logic                  tuser,
   // Input video timing
   input  logic                  i_fstr,
   input  logic                  i_fend,
   input  logic                  i_vstr,
   input  logic                  i_vend,
   input  logic                  i_hstr,
   input  logic                  i_hend,
   input  logic                  i_href,
   // Output video
   output logic                  o_fstr,
   output logic                  o_fend,
   output logic                  o_vstr,
   output logic                  o_vend,
   output logic                  o_hstr,
   output logic                  o_hend,
   output logic                  o_href,
   output video_pkg::pixel_t     o_pdat,
   output video_pkg::vcnv_sts_t  o_vcnv_sts
);

   logic fifo_full;
   logic fifo_push;
   logic in_fblk;
   logic in_bblk;
   logic in_sync;
   logic pop_vld;
   logic pop_str;
   logic pop_cyc_str;

   fifo_rd_if rd_bus ();

   assign tready    = ~fifo_full;
   assign fifo_push = tvalid & tready;
   // Start of frame for the next DMA stage
   assign tuser     = o_fstr;

   stream_fifo fifo (
      .pclk    (pclk),
      .prst_n  (prst_n),
      .i_push  (fifo_push),
      .i_wdata (tdata),
      .o_full  (fifo_full),
      .rd      (rd_bus.fifo_mp)
   );

   vin_tracker vin_trk (
      .pclk   (pclk),
      .prst_n (prst_n),
      .i_fstr (i_fstr),
      .i_vstr (i_vstr),
      .i_vend (i_vend),
      .i_fend (i_fend),
      .o_fblk (in_fblk),
      .o_bblk (in_bblk),
      .o_sync (in_sync)
   );

   vout_timing vout_tm (
      .pclk          (pclk),
      .prst_n        (prst_n),
      .i_fstr        (i_fstr),
      .i_fend        (i_fend),
      .i_vstr        (i_vstr),
      .i_vend        (i_vend),
      .i_hstr        (i_hstr),
      .i_hend        (i_hend),
      .i_fblk        (in_fblk),
      .i_bblk        (in_bblk),
      .i_sync        (in_sync),
      .i_pop_cyc_str (pop_cyc_str),
      .mon           (rd_bus.mon_mp),
      .o_pop_vld     (pop_vld),
      .o_pop_str     (pop_str),
      .o_fstr        (o_fstr),
      .o_fend        (o_fend),
      .o_vstr        (o_vstr),
      .o_vend        (o_vend),
      .o_hstr        (o_hstr),
      .o_hend        (o_hend),
      .o_href        (o_href),
      .o_vcnv_sts    (o_vcnv_sts)
   );

   pixel_unpack unpack (
      .pclk          (pclk),
      .prst_n        (prst_n),
      .i_pop_vld     (pop_vld),
      .i_pop_str     (pop_str),
      .fifo          (rd_bus.unpack_mp),
      .o_pop_cyc_str (pop_cyc_str),
      .o_pdat        (o_pdat)
   );

endmodule

`default_nettype wire

/* sim/axi4s2v_asserts.sv */
// Protocol checks on the converter outputs
// Attached to axi4s2v by a bind in the testbench
`default_nettype none

module axi4s2v_asserts (
   input logic pclk,
   input logic prst_n,
   input logic o_fstr,
   input logic o_fend,
   input logic o_vstr,
   input logic o_hstr,
   input logic o_href,
   input logic tuser
);

   logic in_frame;
   logic sof_seen;
   // Failed assertions so far
   int   fail_cnt;

   initial begin
      fail_cnt = 0;
   end

   // High between o_fstr and o_fend
   always_ff @(posedge pclk) begin
      if (!prst_n) begin
         in_frame <= 1'b0;
      end else if (o_fstr) begin
         in_frame <= 1'b1;
      end else if (o_fend) begin
         in_frame <= 1'b0;
      end
   end

   // Set by tuser, used up by the first o_vstr of the frame
   always_ff @(posedge pclk) begin
      if (!prst_n) begin
         sof_seen <= 1'b0;
      end else if (tuser) begin
         sof_seen <= 1'b1;
      end else if (o_vstr) begin
         sof_seen <= 1'b0;
      end
   end

   // --------------------
   // Line framing
   href_starts_with_hstr: assert property (
      @(posedge pclk) disable iff (!prst_n) $rose(o_href) |-> o_hstr)
      else begin
         fail_cnt++;
         $error("o_href rose without o_hstr");
      end

   hstr_opens_line: assert property (
      @(posedge pclk) disable iff (!prst_n) o_hstr |-> $rose(o_href))
      else begin
         fail_cnt++;
         $error("o_hstr inside an active line");
      end

   // --------------------
   // Frame framing
   fstr_outside_frame: assert property (
      @(posedge pclk) disable iff (!prst_n) o_fstr |-> !in_frame)
      else begin
         fail_cnt++;
         $error("o_fstr without a preceding o_fend");
      end

   fend_inside_frame: assert property (
      @(posedge pclk) disable iff (!prst_n) o_fend |-> in_frame)
      else begin
         fail_cnt++;
         $error("o_fend without a preceding o_fstr");
      end

   tuser_opens_frame: assert property (
      @(posedge pclk) disable iff (!prst_n) o_vstr |-> sof_seen)
      else begin
         fail_cnt++;
         $error("o_vstr without tuser at the start of the frame");
      end

endmodule

`default_nettype wire

/* sim/tb_axi4s2v.sv */
// Directed testbench for the stream to video converter
// Every line is 16 pixels wide, four stream words per line
// Pixel data is checked only in frames that have enough stream words
`default_nettype none

module tb_axi4s2v;

   localparam int LINE_W      = 16;
   localparam int HBLK        = 8;
   // Front and back blanking of one frame plus checks
   localparam int FRM_OVH     = 16;
   localparam int TOTAL_LINES = 4 + 8 + 4 + 1;
   localparam int SUM_FRAMES  = 5 * FRM_OVH + TOTAL_LINES * (LINE_W + HBLK);
   localparam int CYCLE_LIMIT = 2 * SUM_FRAMES + 1000;

   logic        pclk;
   logic        prst_n;
   logic [31:0] tdata;
   logic        tvalid;
   logic        tlast;
   logic        tready;
   logic        tuser;
   logic        i_fstr;
   logic        i_fend;
   logic        i_vstr;
   logic        i_vend;
   logic        i_hstr;
   logic        i_hend;
   logic        i_href;
   logic        o_fstr;
   logic        o_fend;
   logic        o_vstr;
   logic        o_vend;
   logic        o_hstr;
   logic        o_hend;
   logic        o_href;
   logic [7:0]  o_pdat;
   logic [4:0]  o_vcnv_sts;

   logic [31:0] rng_state;
   logic [7:0]  exp_px [$];
   logic [7:0]  exp_byte;
   logic        px_chk_en;
   int          cycle_cnt;
   int          stall_cnt;
   int          href_run;
   int          n_fstr;
   int          n_fend;
   int          n_vstr;
   int          n_vend;
   int          n_hstr;
   int          n_tuser;

   axi4s2v i_dut (.*);

   bind axi4s2v axi4s2v_asserts i_asserts (
      .pclk   (pclk),
      .prst_n (prst_n),
      .o_fstr (o_fstr),
      .o_fend (o_fend),
      .o_vstr (o_vstr),
      .o_hstr (o_hstr),
      .o_href (o_href),
      .tuser  (tuser)
   );

   initial begin
      pclk = 1'b0;
   end

   always #10 pclk = ~pclk;

   always @(posedge pclk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (i_dut.i_asserts.fail_cnt != 0) begin
         $display("ERROR: a protocol assertion failed before time %0t", $time);
         $display("Done: errors found");
         $fatal(1);
      end else if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("ERROR: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Done: errors found");
         $fatal(1);
      end
   end

   // --------------------
   // Helpers
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      if (got !== exp) begin
         $display("ERROR at time %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
         $display("Done: errors found");
         $fatal(1);
      end
   endtask

   task automatic clear_counts();
      n_fstr  = 0;
      n_fend  = 0;
      n_vstr  = 0;
      n_vend  = 0;
      n_hstr  = 0;
      n_tuser = 0;
   endtask

   // Sender holds each word until tready is seen high
   task automatic push_words(input int n);
      logic [31:0] w;
      for (int i = 0; i < n; i++) begin
         rng_state = xorshift32(rng_state);
         w = rng_state;
         for (int b = 0; b < 4; b++) begin
            exp_px.push_back(w[8*b +: 8]);
         end
         @(posedge pclk);
         tdata  <= w;
         tvalid <= 1'b1;
         @(negedge pclk);
         while (!tready) begin
            stall_cnt++;
            @(negedge pclk);
         end
      end
      @(posedge pclk);
      tvalid <= 1'b0;
   endtask

   task automatic start_frame();
      @(posedge pclk);
      i_fstr <= 1'b1;
      @(posedge pclk);
      i_fstr <= 1'b0;
      repeat (4) @(posedge pclk);
   endtask

   // i_vstr with the first i_hstr, i_vend with the last i_hend
   task automatic drive_lines(input int n_lines, input int width);
      for (int l = 0; l < n_lines; l++) begin
         for (int p = 0; p < width; p++) begin
            @(posedge pclk);
            i_hstr <= (p == 0);
            i_vstr <= (p == 0) && (l == 0);
            i_href <= 1'b1;
            i_hend <= (p == width - 1);
            i_vend <= (p == width - 1) && (l == n_lines - 1);
         end
         @(posedge pclk);
         i_hstr <= 1'b0;
         i_vstr <= 1'b0;
         i_href <= 1'b0;
         i_hend <= 1'b0;
         i_vend <= 1'b0;
         repeat (HBLK - 1) @(posedge pclk);
      end
   endtask

   task automatic end_frame();
      @(posedge pclk);
      i_fend <= 1'b1;
      @(posedge pclk);
      i_fend <= 1'b0;
      repeat (6) @(posedge pclk);
   endtask

   // --------------------
   // Output monitor
   always @(negedge pclk) begin
      if (prst_n) begin
         if (o_fstr) n_fstr++;
         if (o_fend) n_fend++;
         if (o_vstr) n_vstr++;
         if (o_vend) n_vend++;
         if (o_hstr) n_hstr++;
         if (tuser) n_tuser++;
         if (o_href) begin
            // Line end marker on the last active pixel only
            check_val("o_hend", o_hend, href_run == LINE_W - 1);
            href_run++;
            if (px_chk_en) begin
               check_val("expected pixels left", exp_px.size() > 0, 1);
               exp_byte = exp_px.pop_front();
               check_val("o_pdat", o_pdat, exp_byte);
            end
         end else begin
            check_val("o_hend", o_hend, 0);
            if (href_run != 0) begin
               check_val("o_href line length", href_run, LINE_W);
               href_run = 0;
            end
         end
      end
   end

   // --------------------
   // Directed tests
   task automatic reset_values();
      @(negedge pclk);
      check_val("tready", tready, 1);
      check_val("tuser", tuser, 0);
      check_val("o_fstr", o_fstr, 0);
      check_val("o_fend", o_fend, 0);
      check_val("o_vstr", o_vstr, 0);
      check_val("o_vend", o_vend, 0);
      check_val("o_hstr", o_hstr, 0);
      check_val("o_hend", o_hend, 0);
      check_val("o_href", o_href, 0);
      check_val("o_vcnv_sts", o_vcnv_sts, 0);
   endtask

   task automatic single_frame();
      clear_counts();
      px_chk_en = 1'b1;
      push_words(16);
      start_frame();
      drive_lines(4, LINE_W);
      end_frame();
      check_val("o_fstr count", n_fstr, 1);
      check_val("o_vstr count", n_vstr, 1);
      check_val("o_hstr count", n_hstr, 4);
      check_val("o_vend count", n_vend, 1);
      check_val("o_fend count", n_fend, 1);
      check_val("tuser count", n_tuser, 1);
      check_val("pixels not output", exp_px.size(), 0);
      check_val("o_vcnv_sts", o_vcnv_sts, 0);
   endtask

   task automatic back_pressure();
      clear_counts();
      stall_cnt = 0;
      push_words(32);
      check_val("stall cycles", stall_cnt, 0);
      @(negedge pclk);
      check_val("tready", tready, 0);
      start_frame();
      drive_lines(8, LINE_W);
      end_frame();
      check_val("o_hstr count", n_hstr, 8);
      check_val("pixels not output", exp_px.size(), 0);
      check_val("tready", tready, 1);
   endtask

   // Too few words, lines 3 and 4 find the FIFO empty
   task automatic not_ready_flags();
      clear_counts();
      px_chk_en = 1'b0;
      push_words(4);
      exp_px.delete();
      start_frame();
      drive_lines(4, LINE_W);
      @(negedge pclk);
      check_val("o_vcnv_sts[3:0]", o_vcnv_sts[3:0], 4'b1110);
      end_frame();
      @(negedge pclk);
      check_val("o_vcnv_sts[3:1]", o_vcnv_sts[3:1], 3'b000);
   endtask

   task automatic early_frame_end();
      clear_counts();
      start_frame();
      end_frame();
      @(negedge pclk);
      check_val("o_vcnv_sts[4]", o_vcnv_sts[4], 1);
      start_frame();
      @(negedge pclk);
      check_val("o_vcnv_sts[4]", o_vcnv_sts[4], 1);
      drive_lines(1, LINE_W);
      @(negedge pclk);
      check_val("o_vcnv_sts[4]", o_vcnv_sts[4], 0);
      end_frame();
      @(negedge pclk);
      check_val("o_vcnv_sts[4]", o_vcnv_sts[4], 0);
      check_val("o_fend count", n_fend, 2);
   endtask

   // --------------------
   initial begin
      cycle_cnt = 0;
      stall_cnt = 0;
      href_run  = 0;
      px_chk_en = 1'b0;
      rng_state = 32'hc292ad8b;
      clear_counts();
      prst_n = 1'b0;
      tdata  = '0;
      tvalid = 1'b0;
      tlast  = 1'b0;
      i_fstr = 1'b0;
      i_fend = 1'b0;
      i_vstr = 1'b0;
      i_vend = 1'b0;
      i_hstr = 1'b0;
      i_hend = 1'b0;
      i_href = 1'b0;
      repeat (8) @(posedge pclk);
      prst_n <= 1'b1;
      reset_values();
      single_frame();
      back_pressure();
      not_ready_flags();
      early_frame_end();
      @(negedge pclk);
      if (i_dut.i_asserts.fail_cnt == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* axi4s2v.f */
+incdir+hdl
hdl/axis_pkg.sv
hdl/video_pkg.sv
hdl/fifo_rd_if.sv
hdl/stream_fifo.sv
hdl/vin_tracker.sv
hdl/vout_timing.sv
hdl/pixel_unpack.sv
hdl/axi4s2v.sv
sim/axi4s2v_asserts.sv
sim/tb_axi4s2v.sv
